// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module execute_tb -Mdir obj_dir -o execute_tb

run: compile
	./obj_dir/execute_tb | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim.f ====
source/exec_op_pkg.sv
source/exec_flag_pkg.sv
source/exec_uop_if.sv
source/alu_unit.sv
source/eflags_reg.sv
source/pointer_adjust.sv
source/branch_resolve.sv
source/execute_top.sv
testbench/execute_tb.sv

// ==== source/alu_unit.sv ====
/* Combinational ALU for res1 and arithmetic flags. Narrow results keep op1 upper bits;
   shift counts above the operand width give x86-undefined flags, not modelled */
module alu_unit (
    exec_uop_if.exec               uop,
    input  exec_flag_pkg::eflags_t flags,
    output logic [31:0]            res1,
    output logic                   res1_wb,
    output exec_flag_pkg::eflags_t flag_new,
    output exec_flag_pkg::eflags_t flag_wr
);

    logic [31:0] mask;
    logic [4:0]  msb;
    logic [5:0]  top_bit;   // First bit above the sized width
    logic [31:0] a_m, b_m, a_sx;
    logic [32:0] sum;
    logic [63:0] sal_w, sar_w;
    logic [4:0]  cnt;
    logic [31:0] raw, r;
    logic        wr_en;

    assign mask    = exec_op_pkg::size_mask(uop.size);
    assign msb     = exec_op_pkg::size_msb(uop.size);
    assign top_bit = {1'b0, msb} + 6'd1;
    assign cnt     = uop.op2[4:0];
    assign a_m     = uop.op1 & mask;
    assign b_m     = uop.op2 & mask;
    assign a_sx    = a_m | (a_m[msb] ? ~mask : 32'h0);  // Sign extended from msb
    assign sum     = {1'b0, a_m} + {1'b0, b_m};
    assign sal_w   = {32'h0, a_m} << cnt;
    assign sar_w   = $signed({a_sx, 32'h0}) >>> cnt;    // Bit 31 is last bit out

    always_comb begin
        raw   = uop.op1;
        wr_en = 1'b1;
        case (uop.op)
            exec_op_pkg::OP_ADD:       raw = sum[31:0];
            exec_op_pkg::OP_AND:       raw = uop.op1 & uop.op2;
            exec_op_pkg::OP_OR:        raw = uop.op1 | uop.op2;
            exec_op_pkg::OP_NOT:       raw = ~uop.op1;
            exec_op_pkg::OP_SAL:       raw = sal_w[31:0];
            exec_op_pkg::OP_SAR:       raw = sar_w[63:32];
            exec_op_pkg::OP_MOV:       raw = uop.op2;
            exec_op_pkg::OP_CMOVC: begin
                raw   = flags[exec_flag_pkg::CF_BIT] ? uop.op2 : uop.op1;
                wr_en = flags[exec_flag_pkg::CF_BIT];   // Failed move writes nothing
            end
            exec_op_pkg::OP_CALL_NEAR: raw = uop.eip;   // Return address to push
            default:                   wr_en = 1'b0;
        endcase
    end

    assign r       = raw & mask;
    assign res1    = r | (uop.op1 & ~mask);
    assign res1_wb = uop.go & wr_en;

    always_comb begin
        flag_new = '0;
        flag_wr  = '0;
        flag_new[exec_flag_pkg::ZF_BIT] = (r == 32'h0);
        flag_new[exec_flag_pkg::SF_BIT] = r[msb];
        flag_new[exec_flag_pkg::PF_BIT] = ~^r[7:0];     // Even parity, low byte only
        case (uop.op)
            exec_op_pkg::OP_ADD: begin
                flag_new[exec_flag_pkg::CF_BIT] = sum[top_bit];
                flag_new[exec_flag_pkg::AF_BIT] = a_m[4] ^ b_m[4] ^ r[4];
                flag_new[exec_flag_pkg::OF_BIT] = (a_m[msb] == b_m[msb]) && (r[msb] != a_m[msb]);
            end
            exec_op_pkg::OP_SAL: flag_new[exec_flag_pkg::CF_BIT] = sal_w[top_bit];
            exec_op_pkg::OP_SAR: flag_new[exec_flag_pkg::CF_BIT] = sar_w[31];
            default: ;                                  // AND and OR leave CF, AF, OF at 0
        endcase

        if (uop.op inside {exec_op_pkg::OP_ADD, exec_op_pkg::OP_AND, exec_op_pkg::OP_OR}) begin
            flag_wr[exec_flag_pkg::CF_BIT] = 1'b1;
            flag_wr[exec_flag_pkg::PF_BIT] = 1'b1;
            flag_wr[exec_flag_pkg::AF_BIT] = 1'b1;
            flag_wr[exec_flag_pkg::ZF_BIT] = 1'b1;
            flag_wr[exec_flag_pkg::SF_BIT] = 1'b1;
            flag_wr[exec_flag_pkg::OF_BIT] = 1'b1;
        end else if (uop.op inside {exec_op_pkg::OP_SAL, exec_op_pkg::OP_SAR} && cnt != 5'd0) begin
            flag_wr[exec_flag_pkg::CF_BIT] = 1'b1;
            flag_wr[exec_flag_pkg::PF_BIT] = 1'b1;
            flag_wr[exec_flag_pkg::ZF_BIT] = 1'b1;
            flag_wr[exec_flag_pkg::SF_BIT] = 1'b1;
        end
    end

    // No register write may leak out of a stalled or idle cycle
    a_wb_needs_go: assert property (@(posedge uop.clk) !uop.go |-> !res1_wb);

endmodule

// ==== source/branch_resolve.sv ====
/* Near branch resolution against the front end's prediction.
   Only CF and ZF conditions are supported */
module branch_resolve (
    exec_uop_if.exec               uop,
    input  exec_flag_pkg::eflags_t flags,
    input  logic                   pred_taken,
    input  logic [31:0]            pred_target,
    output logic                   br_valid,
    output logic                   br_taken,
    output logic                   br_correct,
    output logic [31:0]            br_target
);

    logic cond_ok;
    logic is_br;

    assign is_br = uop.op inside {exec_op_pkg::OP_JMP_NEAR, exec_op_pkg::OP_JCC,
                                  exec_op_pkg::OP_CALL_NEAR, exec_op_pkg::OP_RET};

    always_comb begin
        case (uop.cond)
            exec_flag_pkg::COND_ALWAYS: cond_ok = 1'b1;
            exec_flag_pkg::COND_C:      cond_ok = flags[exec_flag_pkg::CF_BIT];
            exec_flag_pkg::COND_NC:     cond_ok = !flags[exec_flag_pkg::CF_BIT];
            exec_flag_pkg::COND_Z:      cond_ok = flags[exec_flag_pkg::ZF_BIT];
            exec_flag_pkg::COND_NZ:     cond_ok = !flags[exec_flag_pkg::ZF_BIT];
            default:                    cond_ok = 1'b0;
        endcase
    end

    assign br_taken = (uop.op == exec_op_pkg::OP_JCC) ? cond_ok : is_br;

    always_comb begin
        if (uop.op == exec_op_pkg::OP_RET) begin
            br_target = uop.op1;                // Popped return address
        end else if (br_taken) begin
            br_target = uop.eip + uop.op2;      // Relative displacement
        end else begin
            br_target = uop.eip;                // Fall through
        end
    end

    assign br_valid   = uop.go & is_br;
    assign br_correct = br_valid && (pred_taken == br_taken) &&
                        (!br_taken || pred_target == br_target);

    // Front end only acts on a match for a real branch
    a_correct_valid: assert property (@(posedge uop.clk) br_correct |-> br_valid);

endmodule

// ==== source/eflags_reg.sv ====
/* Flags register, written only in cycles with go high.
   Unimplemented bits are forced to zero on every load */
module eflags_reg (
    input  logic                   clk,
    input  logic                   reset,
    exec_uop_if.exec               uop,
    input  exec_flag_pkg::eflags_t flag_new,
    input  exec_flag_pkg::eflags_t flag_wr,
    output exec_flag_pkg::eflags_t flags
);

    exec_flag_pkg::eflags_t next_flags;

    always_comb begin
        next_flags = (flags & ~flag_wr) | (flag_new & flag_wr);
        if (uop.op == exec_op_pkg::OP_CLD) begin
            next_flags[exec_flag_pkg::DF_BIT] = 1'b0;
        end else if (uop.op == exec_op_pkg::OP_STD) begin
            next_flags[exec_flag_pkg::DF_BIT] = 1'b1;
        end
        next_flags = next_flags & exec_flag_pkg::FLAG_IMPL_MASK;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (uop.go) begin
            flags <= next_flags;
        end
    end

    // String direction must be forward for the op after an issued CLD
    a_cld_clears_df: assert property (@(posedge clk) disable iff (reset)
        uop.go && uop.op == exec_op_pkg::OP_CLD |=> !flags[exec_flag_pkg::DF_BIT]);

    // Stall or bubble leaves architectural flags alone
    a_hold_no_go: assert property (@(posedge clk) disable iff (reset)
        !uop.go |=> $stable(flags));

endmodule

// ==== source/exec_flag_pkg.sv ====
/* Flags word layout and branch conditions. Only CF, PF, AF, ZF, SF, DF and OF
   are implemented; every other bit of the word reads as zero */
package exec_flag_pkg;

    typedef logic [17:0] eflags_t;

    localparam int CF_BIT = 0;
    localparam int PF_BIT = 1;
    localparam int AF_BIT = 2;
    localparam int ZF_BIT = 3;
    localparam int SF_BIT = 4;
    localparam int DF_BIT = 7;
    localparam int OF_BIT = 8;

    // Bits that hold state
    localparam eflags_t FLAG_IMPL_MASK = 18'h0019f;

    typedef enum logic [2:0] {
        COND_ALWAYS,
        COND_C,
        COND_NC,
        COND_Z,
        COND_NZ
    } cond_t;

endpackage

// ==== source/exec_op_pkg.sv ====
/* Operation codes and operand-size helpers shared by the execute datapath.
   Data width is fixed at 32 bits; sizes other than byte, word and dword are not encoded */
package exec_op_pkg;

    typedef enum logic [4:0] {
        OP_ADD, OP_AND, OP_OR, OP_NOT, OP_SAL, OP_SAR, OP_MOV, OP_CMOVC,
        OP_MOVS, OP_PUSH, OP_POP, OP_CALL_NEAR, OP_RET,
        OP_JMP_NEAR, OP_JCC, OP_CLD, OP_STD
    } exec_op_t;

    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } op_size_t;

    // Byte count of one element
    function automatic logic [31:0] size_step(op_size_t sz);
        case (sz)
            SIZE_BYTE: return 32'd1;
            SIZE_WORD: return 32'd2;
            default:   return 32'd4;
        endcase
    endfunction

    function automatic logic [4:0] size_msb(op_size_t sz);
        case (sz)
            SIZE_BYTE: return 5'd7;
            SIZE_WORD: return 5'd15;
            default:   return 5'd31;
        endcase
    endfunction

    // Ones over the live bits of a size
    function automatic logic [31:0] size_mask(op_size_t sz);
        case (sz)
            SIZE_BYTE: return 32'h0000_00ff;
            SIZE_WORD: return 32'h0000_ffff;
            default:   return 32'hffff_ffff;
        endcase
    endfunction

endpackage

// ==== source/exec_uop_if.sv ====
/* One decoded micro-operation as seen by the execute blocks.
   Fields only count in a cycle where go is high */
interface exec_uop_if (
    input logic clk     // Sampling clock for checks in the datapath blocks
);

    logic                    go;    // valid_in and not fwd_stall
    exec_op_pkg::exec_op_t   op;
    exec_op_pkg::op_size_t   size;
    exec_flag_pkg::cond_t    cond;
    logic [31:0]             op1;
    logic [31:0]             op2;
    logic [31:0]             op3;   // String pointer
    logic [31:0]             op4;   // Stack pointer
    logic [31:0]             eip;   // Next sequential instruction

    modport issue (
        output go, op, size, cond,
        output op1, op2, op3, op4, eip
    );

    modport exec (
        input clk,
        input go, op, size, cond,
        input op1, op2, op3, op4, eip
    );

endinterface

// ==== source/execute_top.sv ====
/* Execute stage, one micro-op per cycle, all results combinational.
   fwd_stall holds the stage; upstream must keep its inputs until it clears */
module execute_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          valid_in,
    input  logic                          fwd_stall,
    input  exec_op_pkg::exec_op_t         op,
    input  exec_op_pkg::op_size_t         size,
    input  exec_flag_pkg::cond_t          cond,
    input  logic [31:0]                   op1,
    input  logic [31:0]                   op2,
    input  logic [31:0]                   op3,
    input  logic [31:0]                   op4,
    input  logic [31:0]                   eip,
    input  logic                          pred_taken,
    input  logic [31:0]                   pred_target,
    output logic                          stall,
    output logic                          valid_out,
    output logic [31:0]                   res1,
    output logic                          res1_wb,
    output logic [31:0]                   res2,
    output logic                          res2_wb,
    output logic [31:0]                   res3,
    output logic                          res3_wb,
    output exec_flag_pkg::eflags_t        eflags,
    output logic                          br_valid,
    output logic                          br_taken,
    output logic                          br_correct,
    output logic [31:0]                   br_target
);

    exec_flag_pkg::eflags_t flag_new;
    exec_flag_pkg::eflags_t flag_wr;

    exec_uop_if uop (.clk(clk));

    assign stall     = valid_in & fwd_stall;
    assign uop.go    = valid_in & ~fwd_stall;
    assign valid_out = uop.go;

    assign uop.op   = op;
    assign uop.size = size;
    assign uop.cond = cond;
    assign uop.op1  = op1;
    assign uop.op2  = op2;
    assign uop.op3  = op3;
    assign uop.op4  = op4;
    assign uop.eip  = eip;

    alu_unit u_alu (
        .uop      (uop.exec),
        .flags    (eflags),
        .res1     (res1),
        .res1_wb  (res1_wb),
        .flag_new (flag_new),
        .flag_wr  (flag_wr)
    );

    eflags_reg u_eflags (
        .clk      (clk),
        .reset    (reset),
        .uop      (uop.exec),
        .flag_new (flag_new),
        .flag_wr  (flag_wr),
        .flags    (eflags)
    );

    pointer_adjust u_ptr (
        .uop     (uop.exec),
        .flags   (eflags),
        .res2    (res2),
        .res2_wb (res2_wb),
        .res3    (res3),
        .res3_wb (res3_wb)
    );

    branch_resolve u_br (
        .uop         (uop.exec),
        .flags       (eflags),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_correct  (br_correct),
        .br_target   (br_target)
    );

endmodule

// ==== source/pointer_adjust.sv ====
/* String and stack pointer steppers. Stack moves are always 4 bytes;
   string steps follow the operand size and DF */
module pointer_adjust (
    exec_uop_if.exec               uop,
    input  exec_flag_pkg::eflags_t flags,
    output logic [31:0]            res2,
    output logic                   res2_wb,
    output logic [31:0]            res3,
    output logic                   res3_wb
);

    logic [31:0] step;
    logic        is_movs;
    logic        is_push;   // PUSH or CALL_NEAR
    logic        is_pop;    // POP or RET

    assign step    = exec_op_pkg::size_step(uop.size);
    assign is_movs = (uop.op == exec_op_pkg::OP_MOVS);
    assign is_push = (uop.op == exec_op_pkg::OP_PUSH) || (uop.op == exec_op_pkg::OP_CALL_NEAR);
    assign is_pop  = (uop.op == exec_op_pkg::OP_POP) || (uop.op == exec_op_pkg::OP_RET);

    // String pointer, down when DF is set
    always_comb begin
        if (flags[exec_flag_pkg::DF_BIT]) begin
            res2 = uop.op3 - step;
        end else begin
            res2 = uop.op3 + step;
        end
    end

    assign res2_wb = uop.go & is_movs;

    // Stack grows down
    always_comb begin
        if (is_push) begin
            res3 = uop.op4 - 32'd4;
        end else begin
            res3 = uop.op4 + 32'd4;
        end
    end

    assign res3_wb = uop.go & (is_push | is_pop);

    // Write-back has one pointer port per cycle for these two
    a_one_pointer: assert property (@(posedge uop.clk) !(res2_wb && res3_wb));

endmodule

// ==== testbench/execute_tb.sv ====
/* Testbench for execute_top. Each op is checked at the rising edge that ends its cycle,
   against a reference model that keeps its own flags copy */
module execute_tb;

    typedef struct packed {
        logic [31:0]            res1;
        logic                   res1_wb;
        logic [31:0]            res2;
        logic                   res2_wb;
        logic [31:0]            res3;
        logic                   res3_wb;
        logic                   valid_out;
        logic                   stall;
        logic                   br_valid;
        logic                   br_taken;
        logic                   br_correct;
        logic [31:0]            br_target;
        exec_flag_pkg::eflags_t flags_next;
    } expect_t;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic                   valid_in;
    logic                   fwd_stall;
    exec_op_pkg::exec_op_t  op;
    exec_op_pkg::op_size_t  size;
    exec_flag_pkg::cond_t   cond;
    logic [31:0]            op1, op2, op3, op4, eip;
    logic                   pred_taken;
    logic [31:0]            pred_target;
    logic                   stall, valid_out, res1_wb, res2_wb, res3_wb;
    logic [31:0]            res1, res2, res3, br_target;
    exec_flag_pkg::eflags_t eflags;
    logic                   br_valid, br_taken, br_correct;

    exec_flag_pkg::eflags_t model_flags = '0;
    integer                 seed = 32'he423;
    int                     errors = 0;
    int                     checks = 0;
    int                     err_mark = 0;

    execute_top uut (.*);

    always #4 clk = ~clk;

    // Expected outputs of one cycle, from the stage's rules
    function automatic expect_t exec_model(
        input logic vin, input logic fst, input exec_op_pkg::exec_op_t o,
        input exec_op_pkg::op_size_t sz, input exec_flag_pkg::cond_t cc,
        input logic [31:0] a_in, input logic [31:0] b_in, input logic [31:0] sp,
        input logic [31:0] stk, input logic [31:0] nip, input logic pt,
        input logic [31:0] ptgt, input exec_flag_pkg::eflags_t f);
        expect_t     e;
        int          w, i, cnt;
        logic [31:0] m, a, b, r, v, step;
        logic [32:0] full;
        logic        go, cf, af, ovf, hit, wr_arith, wr_shift;
        w = (sz == exec_op_pkg::SIZE_BYTE) ? 8 : (sz == exec_op_pkg::SIZE_WORD) ? 16 : 32;
        m = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
        step = (w == 8) ? 32'd1 : (w == 16) ? 32'd2 : 32'd4;
        a = a_in & m;
        b = b_in & m;
        cnt = {27'd0, b_in[4:0]};
        go = vin && !fst;
        e = '0;
        e.flags_next = f;
        e.valid_out = go;
        e.stall = vin && fst;
        r = a;
        cf = 1'b0;
        af = 1'b0;
        ovf = 1'b0;
        wr_arith = 1'b0;
        wr_shift = 1'b0;
        case (o)
            exec_op_pkg::OP_ADD: begin
                full = {1'b0, a} + {1'b0, b};
                r = full[31:0] & m;
                cf = full[w];
                af = ((a & 32'hf) + (b & 32'hf)) > 32'hf;   // Carry out of bit 3
                ovf = (a[w-1] == b[w-1]) && (r[w-1] != a[w-1]);
                wr_arith = 1'b1;
                e.res1_wb = go;
            end
            exec_op_pkg::OP_AND, exec_op_pkg::OP_OR: begin
                r = (o == exec_op_pkg::OP_AND) ? (a & b) : (a | b);
                wr_arith = 1'b1;
                e.res1_wb = go;
            end
            exec_op_pkg::OP_NOT: begin
                r = ~a & m;
                e.res1_wb = go;
            end
            exec_op_pkg::OP_SAL, exec_op_pkg::OP_SAR: begin
                v = a;
                for (i = 0; i < cnt; i++) begin     // One bit per step
                    if (o == exec_op_pkg::OP_SAL) begin
                        cf = v[w-1];
                        v = (v << 1) & m;
                    end else begin
                        cf = v[0];
                        v = (v >> 1) | (v & (32'd1 << (w - 1)));
                    end
                end
                r = v;
                wr_shift = (cnt != 0);
                e.res1_wb = go;
            end
            exec_op_pkg::OP_MOV: begin
                r = b;
                e.res1_wb = go;
            end
            exec_op_pkg::OP_CMOVC: begin
                r = f[exec_flag_pkg::CF_BIT] ? b : a;
                e.res1_wb = go && f[exec_flag_pkg::CF_BIT];
            end
            exec_op_pkg::OP_CALL_NEAR: begin
                r = nip & m;
                e.res1_wb = go;
            end
            default: ;
        endcase
        e.res1 = (a_in & ~m) | r;
        if (go && (wr_arith || wr_shift)) begin
            e.flags_next[exec_flag_pkg::CF_BIT] = cf;
            e.flags_next[exec_flag_pkg::ZF_BIT] = (r == 32'h0);
            e.flags_next[exec_flag_pkg::SF_BIT] = r[w-1];
            e.flags_next[exec_flag_pkg::PF_BIT] = ~^r[7:0];
            if (wr_arith) begin
                e.flags_next[exec_flag_pkg::AF_BIT] = af;
                e.flags_next[exec_flag_pkg::OF_BIT] = ovf;
            end
        end
        if (go && o == exec_op_pkg::OP_CLD) begin
            e.flags_next[exec_flag_pkg::DF_BIT] = 1'b0;
        end
        if (go && o == exec_op_pkg::OP_STD) begin
            e.flags_next[exec_flag_pkg::DF_BIT] = 1'b1;
        end
        e.res2_wb = go && (o == exec_op_pkg::OP_MOVS);
        e.res2 = f[exec_flag_pkg::DF_BIT] ? (sp - step) : (sp + step);
        e.res3_wb = go && (o inside {exec_op_pkg::OP_PUSH, exec_op_pkg::OP_CALL_NEAR,
                                     exec_op_pkg::OP_POP, exec_op_pkg::OP_RET});
        e.res3 = (o == exec_op_pkg::OP_PUSH || o == exec_op_pkg::OP_CALL_NEAR) ?
                 (stk - 32'd4) : (stk + 32'd4);
        case (cc)
            exec_flag_pkg::COND_ALWAYS: hit = 1'b1;
            exec_flag_pkg::COND_C:      hit = f[exec_flag_pkg::CF_BIT];
            exec_flag_pkg::COND_NC:     hit = !f[exec_flag_pkg::CF_BIT];
            exec_flag_pkg::COND_Z:      hit = f[exec_flag_pkg::ZF_BIT];
            exec_flag_pkg::COND_NZ:     hit = !f[exec_flag_pkg::ZF_BIT];
            default:                    hit = 1'b0;
        endcase
        e.br_valid = go && (o inside {exec_op_pkg::OP_JMP_NEAR, exec_op_pkg::OP_JCC,
                                      exec_op_pkg::OP_CALL_NEAR, exec_op_pkg::OP_RET});
        e.br_taken = (o == exec_op_pkg::OP_JCC) ? hit :
                     (o inside {exec_op_pkg::OP_JMP_NEAR, exec_op_pkg::OP_CALL_NEAR,
                                exec_op_pkg::OP_RET});
        e.br_target = (o == exec_op_pkg::OP_RET) ? a_in : (e.br_taken ? nip + b_in : nip);
        e.br_correct = e.br_valid && (pt == e.br_taken) &&
                       (!e.br_taken || ptgt == e.br_target);
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] expv,
                             input logic [31:0] got);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("MISMATCH t=%0t %s expected=%h got=%h", $time, name, expv, got);
        end
    endtask

    // Inputs of the ending cycle are still visible here, their updates are non-blocking
    always @(posedge clk) begin : compare
        expect_t e;
        if (!reset) begin
            e = exec_model(valid_in, fwd_stall, op, size, cond, op1, op2, op3, op4, eip,
                           pred_taken, pred_target, model_flags);
            check_val("eflags", model_flags, eflags);
            check_val("valid_out", e.valid_out, valid_out);
            check_val("stall", e.stall, stall);
            check_val("res1_wb", e.res1_wb, res1_wb);
            if (e.res1_wb || (e.valid_out && op == exec_op_pkg::OP_CMOVC)) begin
                check_val("res1", e.res1, res1);
            end
            check_val("res2_wb", e.res2_wb, res2_wb);
            if (e.res2_wb) begin
                check_val("res2", e.res2, res2);
            end
            check_val("res3_wb", e.res3_wb, res3_wb);
            if (e.res3_wb) begin
                check_val("res3", e.res3, res3);
            end
            check_val("br_valid", e.br_valid, br_valid);
            check_val("br_correct", e.br_correct, br_correct);
            if (e.br_valid) begin
                check_val("br_taken", e.br_taken, br_taken);
                check_val("br_target", e.br_target, br_target);
            end
            model_flags = e.flags_next;
        end
    end

    // pmode bit 0 is pred_taken, bit 1 selects the right target
    task automatic issue(input exec_op_pkg::exec_op_t o, input exec_op_pkg::op_size_t sz,
                         input exec_flag_pkg::cond_t cc, input logic [31:0] a,
                         input logic [31:0] b, input logic [1:0] pmode);
        logic [31:0] nip;
        logic [31:0] good;
        nip = $random(seed);
        good = (o == exec_op_pkg::OP_RET) ? a : nip + b;
        @(posedge clk);
        valid_in <= 1'b1;
        fwd_stall <= 1'b0;
        op <= o;
        size <= sz;
        cond <= cc;
        op1 <= a;
        op2 <= b;
        op3 <= $random(seed);
        op4 <= $random(seed);
        eip <= nip;
        pred_taken <= pmode[0];
        pred_target <= pmode[1] ? good : good ^ 32'h40;
    endtask

    // Hold the current op stalled for n cycles, then let it go
    task automatic hold_stalled(input int n);
        fwd_stall <= 1'b1;      // Stalled from the op's first cycle
        repeat (n) begin
            @(posedge clk);
        end
        fwd_stall <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        valid_in <= 1'b0;
        fwd_stall <= 1'b0;
        @(posedge clk);
        @(negedge clk);     // Last op and the idle cycle are checked by now
        $display("%s finished with %0d mismatches", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin : stimulus
        int i, j, k;
        valid_in = 1'b0;
        fwd_stall = 1'b0;
        op = exec_op_pkg::OP_MOV;
        size = exec_op_pkg::SIZE_DWORD;
        cond = exec_flag_pkg::COND_ALWAYS;
        op1 = '0;
        op2 = '0;
        op3 = '0;
        op4 = '0;
        eip = '0;
        pred_taken = 1'b0;
        pred_target = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (i = 0; i < 20 && reset; i++) begin
            @(posedge clk);
        end
        if (reset) begin
            $display("reset was not released within 20 cycles");
            errors++;
        end

        for (i = 0; i < 48; i++) begin      // ADD, AND, OR, NOT at each size
            issue(exec_op_pkg::exec_op_t'(i % 4), exec_op_pkg::op_size_t'(i % 3),
                  exec_flag_pkg::COND_ALWAYS, $random(seed), $random(seed), 2'b00);
        end
        finish_test("alu_logic");

        for (i = 0; i < 32; i++) begin      // Fresh flags before every shift
            issue(exec_op_pkg::OP_ADD, exec_op_pkg::op_size_t'(i % 3),
                  exec_flag_pkg::COND_ALWAYS, $random(seed), $random(seed), 2'b00);
            issue(exec_op_pkg::OP_SAL, exec_op_pkg::op_size_t'(i % 3),
                  exec_flag_pkg::COND_ALWAYS, $random(seed), i, 2'b00);
            issue(exec_op_pkg::OP_SAR, exec_op_pkg::op_size_t'((i + 1) % 3),
                  exec_flag_pkg::COND_ALWAYS, $random(seed), i, 2'b00);
            issue(exec_op_pkg::OP_MOV, exec_op_pkg::op_size_t'(i % 3),
                  exec_flag_pkg::COND_ALWAYS, $random(seed), $random(seed), 2'b00);
        end
        finish_test("shift_mov");

        for (i = 0; i < 2; i++) begin       // Carry set, then carry clear
            issue(exec_op_pkg::OP_ADD, exec_op_pkg::SIZE_DWORD, exec_flag_pkg::COND_ALWAYS,
                  (i == 0) ? 32'hffff_ffff : 32'h1, 32'h1, 2'b00);
            for (j = 0; j < 3; j++) begin
                issue(exec_op_pkg::OP_CMOVC, exec_op_pkg::op_size_t'(j),
                      exec_flag_pkg::COND_ALWAYS, $random(seed), $random(seed), 2'b00);
            end
        end
        finish_test("cmovc");

        for (i = 0; i < 2; i++) begin
            issue((i == 0) ? exec_op_pkg::OP_CLD : exec_op_pkg::OP_STD,
                  exec_op_pkg::SIZE_DWORD, exec_flag_pkg::COND_ALWAYS, 32'h0, 32'h0, 2'b00);
            for (j = 0; j < 3; j++) begin
                issue(exec_op_pkg::OP_MOVS, exec_op_pkg::op_size_t'(j),
                      exec_flag_pkg::COND_ALWAYS, $random(seed), $random(seed), 2'b00);
            end
        end
        issue(exec_op_pkg::OP_PUSH, exec_op_pkg::SIZE_DWORD, exec_flag_pkg::COND_ALWAYS,
              $random(seed), $random(seed), 2'b00);
        issue(exec_op_pkg::OP_POP, exec_op_pkg::SIZE_DWORD, exec_flag_pkg::COND_ALWAYS,
              $random(seed), $random(seed), 2'b00);
        issue(exec_op_pkg::OP_CALL_NEAR, exec_op_pkg::SIZE_DWORD, exec_flag_pkg::COND_ALWAYS,
              $random(seed), $random(seed), 2'b11);
        issue(exec_op_pkg::OP_RET, exec_op_pkg::SIZE_DWORD, exec_flag_pkg::COND_ALWAYS,
              $random(seed), $random(seed), 2'b11);
        finish_test("pointers");

        for (i = 0; i < 3; i++) begin       // CF and ZF set, both clear, ZF only
            issue((i == 2) ? exec_op_pkg::OP_AND : exec_op_pkg::OP_ADD,
                  exec_op_pkg::SIZE_DWORD, exec_flag_pkg::COND_ALWAYS,
                  (i == 0) ? 32'hffff_ffff : 32'h0f, (i == 2) ? 32'hf0 : 32'h1, 2'b00);
            for (j = 0; j < 5; j++) begin
                for (k = 0; k < 4; k++) begin
                    issue(exec_op_pkg::OP_JCC, exec_op_pkg::SIZE_DWORD,
                          exec_flag_pkg::cond_t'(j), $random(seed), $random(seed), 2'(k));
                end
            end
        end
        for (k = 0; k < 4; k++) begin
            issue(exec_op_pkg::OP_JMP_NEAR, exec_op_pkg::SIZE_DWORD,
                  exec_flag_pkg::COND_ALWAYS, $random(seed), $random(seed), 2'(k));
            issue(exec_op_pkg::OP_RET, exec_op_pkg::SIZE_DWORD,
                  exec_flag_pkg::COND_ALWAYS, $random(seed), $random(seed), 2'(k));
        end
        finish_test("branches");

        issue(exec_op_pkg::OP_ADD, exec_op_pkg::SIZE_DWORD, exec_flag_pkg::COND_ALWAYS,
              32'hffff_ffff, 32'h1, 2'b00);
        issue(exec_op_pkg::OP_ADD, exec_op_pkg::SIZE_BYTE, exec_flag_pkg::COND_ALWAYS,
              $random(seed), $random(seed), 2'b00);
        hold_stalled(2);                    // Flags from the first ADD must hold
        issue(exec_op_pkg::OP_PUSH, exec_op_pkg::SIZE_DWORD, exec_flag_pkg::COND_ALWAYS,
              $random(seed), $random(seed), 2'b00);
        hold_stalled(1);
        issue(exec_op_pkg::OP_MOVS, exec_op_pkg::SIZE_WORD, exec_flag_pkg::COND_ALWAYS,
              $random(seed), $random(seed), 2'b00);
        hold_stalled(1);
        issue(exec_op_pkg::OP_JMP_NEAR, exec_op_pkg::SIZE_DWORD, exec_flag_pkg::COND_ALWAYS,
              $random(seed), $random(seed), 2'b11);
        hold_stalled(1);
        finish_test("stall");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int n;
        for (n = 0; n < 5000; n++) begin
            @(posedge clk);
        end
        $display("simulation did not finish within 5000 cycles");
        $display("Test FAILED");
        $finish;
    end

endmodule
